/* design/audio_defines.svh */
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

`define AUD_NUM_FILTERS 4    // filters per channel
`define AUD_MAX_TAPS    16   // delay line and coef table depth
`define AUD_SAMPLE_W    24   // pcm sample width
`define AUD_COEF_W      16   // coef and gain width
`define AUD_ACC_W       48   // mac accumulator
`define AUD_SLOT_BITS   32   // bclk periods per half-frame
`define AUD_COEF_FRAC   15   // q1.15
`define AUD_GAIN_FRAC   14   // q2.14, unity 16384

`endif

/* design/audio_pkg.sv */
`include "audio_defines.svh"

package audio_pkg;

    typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;  // pcm sample
    typedef logic signed [`AUD_COEF_W-1:0]   coef_t;    // q1.15
    typedef logic signed [`AUD_COEF_W-1:0]   gain_t;    // q2.14
    typedef logic signed [`AUD_ACC_W-1:0]    acc_t;     // mac sum
    typedef logic [$clog2(`AUD_NUM_FILTERS)-1:0] filt_idx_t;
    typedef logic [$clog2(`AUD_MAX_TAPS)-1:0]    tap_idx_t;

    typedef enum logic {
        CHAN_LEFT  = 1'b0,  // lrclk low
        CHAN_RIGHT = 1'b1
    } chan_e;

    // clamp an already shifted sum into sample range
    function automatic sample_t sat_sample(acc_t v);
        acc_t hi;
        acc_t lo;
        hi = acc_t'((2 ** (`AUD_SAMPLE_W - 1)) - 1);
        lo = -hi - 1;
        if (v > hi) return sample_t'(hi);
        if (v < lo) return sample_t'(lo);
        return v[`AUD_SAMPLE_W-1:0];
    endfunction

endpackage

/* design/audio_regs_pkg.sv */
package audio_regs_pkg;

    // audio_control register
    typedef struct packed {
        logic [3:0] coef_sel;   // [1:0] picks the filter
        logic       rsvd;
        logic       audio_en;   // samples into fir bank
        logic       eq_bypass;  // all gains unity
        logic       bypass;     // input lines straight to dac
    } ctrl_reg_t;

    // audio_status register
    typedef struct packed {
        logic [6:0] zero;
        logic       coef_addr_zero;  // write pointer at tap 0
    } status_reg_t;

endpackage

/* design/audio_proc_top.sv */
interface i2s_line_if;
    logic bclk;         // synchronized lines
    logic lrclk;
    logic data;
    logic bclk_rise;    // one-cycle strobes
    logic frame_start;  // lrclk fall
    modport source (output bclk, lrclk, data, bclk_rise, frame_start);
    modport sink (input bclk, lrclk, data, bclk_rise, frame_start);
endinterface

interface coef_wr_if;
    import audio_pkg::*;
    logic      wr;
    filt_idx_t filt;
    tap_idx_t  tap;
    coef_t     data;
    modport master (output wr, filt, tap, data);
    modport slave (input wr, filt, tap, data);
endinterface

interface filt_stream_if;
    import audio_pkg::*;
    logic      valid;
    chan_e     chan;
    filt_idx_t filt;
    logic      last;   // final filter of the bank
    sample_t   data;
    modport source (output valid, chan, filt, last, data);
    modport sink (input valid, chan, filt, last, data);
endinterface

module audio_proc_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i2s_bclk,
    input  logic       i2s_lrclk,
    input  logic       i2s_d,
    input  logic       coef_wr_en,
    input  logic       eq_wr_en,
    input  logic [7:0] audio_control,
    input  logic [7:0] equalizer_select,
    input  logic [7:0] taps_per_filter,
    input  logic [7:0] coef_wr_lsb_data,
    input  logic [7:0] coef_wr_msb_data,
    input  logic [7:0] eq_wr_lsb_data,
    input  logic [7:0] eq_wr_msb_data,
    output logic       dac_rst,
    output logic       dac_bclk,
    output logic       dac_lrclk,
    output logic       dac_data,
    output logic [7:0] audio_status
);
    import audio_pkg::*;

    i2s_line_if    line ();
    coef_wr_if     coef_wr ();
    filt_stream_if res ();

    logic      rx_valid;
    chan_e     rx_chan;
    sample_t   rx_sample;
    logic      start;
    chan_e     start_chan;
    sample_t   start_sample;
    tap_idx_t  taps;
    logic      eq_bypass;
    logic      gain_wr;
    filt_idx_t gain_idx;
    gain_t     gain_data;
    logic      bypass;
    logic      out_valid;
    chan_e     out_chan;
    sample_t   out_sample;

    assign dac_rst = !rst_n;  // codec held in reset with us

    i2s_rx u_rx (
        .clk(clk), .rst_n(rst_n),
        .i2s_bclk(i2s_bclk), .i2s_lrclk(i2s_lrclk), .i2s_d(i2s_d),
        .line(line.source),
        .rx_valid(rx_valid), .rx_chan(rx_chan), .rx_sample(rx_sample)
    );

    audio_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .audio_control(audio_control), .taps_per_filter(taps_per_filter),
        .coef_wr_en(coef_wr_en),
        .coef_wr_lsb_data(coef_wr_lsb_data), .coef_wr_msb_data(coef_wr_msb_data),
        .eq_wr_en(eq_wr_en), .equalizer_select(equalizer_select),
        .eq_wr_lsb_data(eq_wr_lsb_data), .eq_wr_msb_data(eq_wr_msb_data),
        .rx_valid(rx_valid), .rx_chan(rx_chan), .rx_sample(rx_sample),
        .coef_wr(coef_wr.master),
        .start(start), .start_chan(start_chan), .start_sample(start_sample),
        .taps(taps), .eq_bypass(eq_bypass),
        .gain_wr(gain_wr), .gain_idx(gain_idx), .gain_data(gain_data),
        .bypass(bypass), .audio_status(audio_status)
    );

    fir_bank u_fir (
        .clk(clk), .rst_n(rst_n),
        .coef_wr(coef_wr.slave),
        .start(start), .start_chan(start_chan), .start_sample(start_sample),
        .taps(taps),
        .res(res.source)
    );

    eq_mixer u_eq (
        .clk(clk), .rst_n(rst_n),
        .res(res.sink), .eq_bypass(eq_bypass),
        .gain_wr(gain_wr), .gain_idx(gain_idx), .gain_data(gain_data),
        .out_valid(out_valid), .out_chan(out_chan), .out_sample(out_sample)
    );

    i2s_tx u_tx (
        .clk(clk), .rst_n(rst_n),
        .line(line.sink), .bypass(bypass),
        .out_valid(out_valid), .out_chan(out_chan), .out_sample(out_sample),
        .dac_bclk(dac_bclk), .dac_lrclk(dac_lrclk), .dac_data(dac_data)
    );

endmodule

/* design/i2s_rx.sv */
`include "audio_defines.svh"

module i2s_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i2s_bclk,
    input  logic               i2s_lrclk,
    input  logic               i2s_d,
    i2s_line_if.source         line,
    output logic               rx_valid,
    output audio_pkg::chan_e   rx_chan,
    output audio_pkg::sample_t rx_sample
);
    import audio_pkg::*;

    logic [2:0] meta;                  // {bclk, lrclk, data}
    logic [2:0] sync;
    logic       bclk_q;
    logic       lrclk_q;
    logic       lr_edge;
    logic [4:0] bit_cnt;               // 0 is the delay bit
    logic [`AUD_SAMPLE_W-2:0] shift;   // bits before the last one

    //////////////////// synchronizer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta    <= '0;
            sync    <= '0;
            bclk_q  <= 1'b0;
            lrclk_q <= 1'b0;
        end else begin
            meta    <= {i2s_bclk, i2s_lrclk, i2s_d};
            sync    <= meta;
            bclk_q  <= sync[2];  // for edge detect
            lrclk_q <= sync[1];
        end
    end

    assign line.bclk        = sync[2];
    assign line.lrclk       = sync[1];
    assign line.data        = sync[0];
    assign line.bclk_rise   = sync[2] && !bclk_q;
    assign line.frame_start = !sync[1] && lrclk_q;  // lrclk fall, left slot
    assign lr_edge          = sync[1] ^ lrclk_q;

    //////////////////// deserializer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (lr_edge) begin
                bit_cnt <= '0;                                  // new slot
            end else if (line.bclk_rise && bit_cnt <= 5'(`AUD_SAMPLE_W)) begin
                bit_cnt <= bit_cnt + 1'b1;                      // stops past last bit
                if (bit_cnt >= 5'd1 && bit_cnt < 5'(`AUD_SAMPLE_W))
                    shift <= {shift[`AUD_SAMPLE_W-3:0], sync[0]};  // msb first
                if (bit_cnt == 5'(`AUD_SAMPLE_W)) begin
                    rx_valid  <= 1'b1;
                    rx_sample <= {shift, sync[0]};
                    rx_chan   <= chan_e'(sync[1]);
                end
            end
        end
    end

    // one sample per slot, never back to back
    a_rx_single: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid);

endmodule

/* design/audio_ctrl.sv */
`include "audio_defines.svh"

module audio_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           audio_control,
    input  logic [7:0]           taps_per_filter,
    input  logic                 coef_wr_en,
    input  logic [7:0]           coef_wr_lsb_data,
    input  logic [7:0]           coef_wr_msb_data,
    input  logic                 eq_wr_en,
    input  logic [7:0]           equalizer_select,
    input  logic [7:0]           eq_wr_lsb_data,
    input  logic [7:0]           eq_wr_msb_data,
    input  logic                 rx_valid,
    input  audio_pkg::chan_e     rx_chan,
    input  audio_pkg::sample_t   rx_sample,
    coef_wr_if.master            coef_wr,
    output logic                 start,
    output audio_pkg::chan_e     start_chan,
    output audio_pkg::sample_t   start_sample,
    output audio_pkg::tap_idx_t  taps,
    output logic                 eq_bypass,
    output logic                 gain_wr,
    output audio_pkg::filt_idx_t gain_idx,
    output audio_pkg::gain_t     gain_data,
    output logic                 bypass,
    output logic [7:0]           audio_status
);
    import audio_pkg::*;
    import audio_regs_pkg::*;

    ctrl_reg_t   ctrl;
    status_reg_t status;
    tap_idx_t    wr_ptr;  // auto-increment tap pointer

    assign ctrl      = ctrl_reg_t'(audio_control);
    assign bypass    = ctrl.bypass;
    assign eq_bypass = ctrl.eq_bypass;

    // index of last tap, 0 or oversize means full depth
    assign taps = (taps_per_filter == 8'd0 || taps_per_filter > 8'(`AUD_MAX_TAPS)) ?
                  tap_idx_t'(`AUD_MAX_TAPS - 1) : tap_idx_t'(taps_per_filter - 8'd1);

    //////////////////// cpu strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            coef_wr.wr <= 1'b0;
            gain_wr    <= 1'b0;
            start      <= 1'b0;
        end else begin
            coef_wr.wr <= coef_wr_en;
            gain_wr    <= eq_wr_en;
            start      <= rx_valid && ctrl.audio_en;  // gate sample starts
            if (coef_wr_en)
                wr_ptr <= (wr_ptr == taps) ? '0 : wr_ptr + 1'b1;  // wrap after last tap
        end
    end

    always_ff @(posedge clk) begin
        if (coef_wr_en) begin
            coef_wr.filt <= filt_idx_t'(ctrl.coef_sel[1:0]);
            coef_wr.tap  <= wr_ptr;
            coef_wr.data <= coef_t'({coef_wr_msb_data, coef_wr_lsb_data});
        end
        if (eq_wr_en) begin
            gain_idx  <= filt_idx_t'(equalizer_select[1:0]);  // modulo 4
            gain_data <= gain_t'({eq_wr_msb_data, eq_wr_lsb_data});
        end
        if (rx_valid) begin
            start_chan   <= rx_chan;
            start_sample <= rx_sample;
        end
    end

    always_comb begin
        status                = '0;
        status.coef_addr_zero = (wr_ptr == '0);
    end
    assign audio_status = status;

    a_start_gated: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ctrl.audio_en);

endmodule

/* design/fir_bank.sv */
`include "audio_defines.svh"

module fir_bank (
    input  logic                clk,
    input  logic                rst_n,
    coef_wr_if.slave            coef_wr,
    input  logic                start,
    input  audio_pkg::chan_e    start_chan,
    input  audio_pkg::sample_t  start_sample,
    input  audio_pkg::tap_idx_t taps,
    filt_stream_if.source       res
);
    import audio_pkg::*;

    localparam int NF = `AUD_NUM_FILTERS;
    localparam int NT = `AUD_MAX_TAPS;

    sample_t   dline [2][NT];  // [chan][age], 0 newest
    coef_t     cmem [NF][NT];  // [filter][tap]
    logic      busy;
    chan_e     chan;
    filt_idx_t filt;
    tap_idx_t  tap;
    tap_idx_t  last_tap;       // latched at start
    acc_t      acc;
    acc_t      acc_sum;

    //////////////////// coefficient memory
    always_ff @(posedge clk) begin
        if (coef_wr.wr)
            cmem[coef_wr.filt][coef_wr.tap] <= coef_wr.data;
    end

    //////////////////// delay lines
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < 2; c++) begin
                for (int t = 0; t < NT; t++) begin
                    dline[c][t] <= '0;
                end
            end
        end else if (start) begin
            dline[start_chan][0] <= start_sample;  // one cycle shift
            for (int t = 1; t < NT; t++) begin
                dline[start_chan][t] <= dline[start_chan][t-1];
            end
        end
    end

    //////////////////// mac sequencer
    assign acc_sum = acc + acc_t'(dline[chan][tap]) * acc_t'(cmem[filt][tap]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            res.valid <= 1'b0;
            filt      <= '0;
            tap       <= '0;
            acc       <= '0;
        end else begin
            res.valid <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                filt     <= '0;
                tap      <= '0;
                acc      <= '0;
                chan     <= start_chan;
                last_tap <= taps;
            end else if (busy) begin
                if (tap == last_tap) begin
                    res.valid <= 1'b1;  // one cycle after last mac
                    res.last  <= (filt == filt_idx_t'(NF - 1));
                    res.filt  <= filt;
                    res.chan  <= chan;
                    res.data  <= sat_sample(acc_sum >>> `AUD_COEF_FRAC);
                    acc       <= '0;
                    tap       <= '0;
                    filt      <= filt + 1'b1;
                    if (filt == filt_idx_t'(NF - 1))
                        busy <= 1'b0;  // bank done
                end else begin
                    acc <= acc_sum;
                    tap <= tap + 1'b1;
                end
            end
        end
    end

    // half-frame rule keeps the sequencer ahead of the input
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

/* design/eq_mixer.sv */
`include "audio_defines.svh"

module eq_mixer (
    input  logic                 clk,
    input  logic                 rst_n,
    filt_stream_if.sink          res,
    input  logic                 eq_bypass,
    input  logic                 gain_wr,
    input  audio_pkg::filt_idx_t gain_idx,
    input  audio_pkg::gain_t     gain_data,
    output logic                 out_valid,
    output audio_pkg::chan_e     out_chan,
    output audio_pkg::sample_t   out_sample
);
    import audio_pkg::*;

    localparam gain_t UNITY = gain_t'(1 << `AUD_GAIN_FRAC);

    gain_t gain [`AUD_NUM_FILTERS];  // gain table
    gain_t g;
    acc_t  acc;
    acc_t  acc_sum;

    assign g       = eq_bypass ? UNITY : gain[res.filt];
    assign acc_sum = acc + acc_t'(res.data) * acc_t'(g);  // weighted sum

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `AUD_NUM_FILTERS; i++) begin
                gain[i] <= UNITY;
            end
        end else if (gain_wr) begin
            gain[gain_idx] <= gain_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (res.valid) begin
                if (res.last) begin
                    out_valid  <= 1'b1;
                    out_chan   <= res.chan;
                    out_sample <= sat_sample(acc_sum >>> `AUD_GAIN_FRAC);
                    acc        <= '0;  // ready for next channel
                end else begin
                    acc <= acc_sum;
                end
            end
        end
    end

endmodule

/* design/i2s_tx.sv */
`include "audio_defines.svh"

module i2s_tx (
    input  logic               clk,
    input  logic               rst_n,
    i2s_line_if.sink           line,
    input  logic               bypass,
    input  logic               out_valid,
    input  audio_pkg::chan_e   out_chan,
    input  audio_pkg::sample_t out_sample,
    output logic               dac_bclk,
    output logic               dac_lrclk,
    output logic               dac_data
);
    import audio_pkg::*;

    localparam int PAD = `AUD_SLOT_BITS - `AUD_SAMPLE_W;

    sample_t next_l;                      // latest processed samples
    sample_t next_r;
    logic [`AUD_SLOT_BITS-1:0] slot_sr;   // slot being sent
    logic    bclk_hi;
    logic    lrclk_q;
    logic    slot_pend;                   // slot edge seen, waiting for a fall
    logic    bclk_fall;
    logic    slot_edge;
    logic    load;

    assign bclk_fall = bclk_hi && !line.bclk;
    assign slot_edge = line.frame_start || (line.lrclk && !lrclk_q);
    assign load      = bclk_fall && (slot_pend || slot_edge);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_l <= '0;
            next_r <= '0;
        end else if (out_valid) begin
            if (out_chan == CHAN_LEFT)
                next_l <= out_sample;
            else
                next_r <= out_sample;
        end
    end

    //////////////////// slot serializer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_hi   <= 1'b0;
            lrclk_q   <= 1'b0;
            slot_pend <= 1'b0;
            slot_sr   <= '0;
        end else begin
            lrclk_q <= line.lrclk;
            if (line.bclk_rise)
                bclk_hi <= 1'b1;
            else if (bclk_fall)
                bclk_hi <= 1'b0;
            if (load)
                slot_pend <= 1'b0;
            else if (slot_edge)
                slot_pend <= 1'b1;
            if (load)  // left on lrclk low, pad bits zero
                slot_sr <= {(line.lrclk ? next_r : next_l), PAD'(0)};
            else if (bclk_fall)
                slot_sr <= slot_sr << 1;
        end
    end

    //////////////////// output registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dac_bclk  <= 1'b0;
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
        end else begin
            dac_bclk  <= line.bclk;   // three cycles behind the pins
            dac_lrclk <= line.lrclk;
            if (bypass)
                dac_data <= line.data;
            else if (load)
                dac_data <= 1'b0;     // i2s delay bit
            else if (bclk_fall)
                dac_data <= slot_sr[`AUD_SLOT_BITS-1];
        end
    end

endmodule

/* verif/audio_proc_tb.sv */
`include "audio_defines.svh"

module audio_proc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 10;
    localparam int BCLK_HALF  = 4;                                  // bclk of 8 clk
    localparam int SW         = `AUD_SAMPLE_W;
    localparam int SLOT       = `AUD_SLOT_BITS;
    localparam int FRAME_CYC  = 2 * SLOT * 2 * BCLK_HALF;          // 512 clk per frame
    localparam int PROC_CYC   = `AUD_NUM_FILTERS * `AUD_MAX_TAPS + 4;  // worst case bank run
    localparam int MAX_TESTS  = 8;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       i2s_bclk;
    logic       i2s_lrclk;
    logic       i2s_d;
    logic       coef_wr_en;
    logic       eq_wr_en;
    logic [7:0] audio_control;
    logic [7:0] equalizer_select;
    logic [7:0] taps_per_filter;
    logic [7:0] coef_wr_lsb_data;
    logic [7:0] coef_wr_msb_data;
    logic [7:0] eq_wr_lsb_data;
    logic [7:0] eq_wr_msb_data;
    logic       dac_rst;
    logic       dac_bclk;
    logic       dac_lrclk;
    logic       dac_data;
    logic [7:0] audio_status;

    // test table, filled by add_test
    string      t_name [MAX_TESTS];
    logic [7:0] t_ctrl [MAX_TESTS];
    int         t_taps [MAX_TESTS];
    int         t_coef_sh [MAX_TESTS];   // coef magnitude shift
    int         t_amp_sh [MAX_TESTS];    // sample magnitude shift
    bit         t_impulse [MAX_TESTS];   // first frame is an impulse
    int         t_frames [MAX_TESTS];
    gain_t      t_gain [MAX_TESTS][`AUD_NUM_FILTERS];
    int         num_tests = 0;

    // reference model state
    sample_t    mdl [2][`AUD_MAX_TAPS];  // [chan][age], 0 newest
    coef_t      mcoef [`AUD_NUM_FILTERS][`AUD_MAX_TAPS];
    gain_t      mgain [`AUD_NUM_FILTERS];
    sample_t    held_l = '0;             // what the dac sends next frame
    sample_t    held_r = '0;
    int         mtaps = `AUD_MAX_TAPS;

    logic [2*SW-1:0] exp_q [$];          // {left, right}
    logic [2*SW-1:0] got_q [$];

    int          errors = 0;
    int          n_checks = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    int          limit = 0;

    audio_proc_top DUT (
        .clk(clk), .rst_n(rst_n),
        .i2s_bclk(i2s_bclk), .i2s_lrclk(i2s_lrclk), .i2s_d(i2s_d),
        .coef_wr_en(coef_wr_en), .eq_wr_en(eq_wr_en),
        .audio_control(audio_control), .equalizer_select(equalizer_select),
        .taps_per_filter(taps_per_filter),
        .coef_wr_lsb_data(coef_wr_lsb_data), .coef_wr_msb_data(coef_wr_msb_data),
        .eq_wr_lsb_data(eq_wr_lsb_data), .eq_wr_msb_data(eq_wr_msb_data),
        .dac_rst(dac_rst), .dac_bclk(dac_bclk), .dac_lrclk(dac_lrclk), .dac_data(dac_data),
        .audio_status(audio_status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: dac frames still missing after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("error @ %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic add_test(input string name, input logic [7:0] ctrl, input int taps,
                            input int coef_sh, input int amp_sh, input bit impulse,
                            input int frames, input gain_t g0, input gain_t g1,
                            input gain_t g2, input gain_t g3);
        t_name[num_tests]    = name;
        t_ctrl[num_tests]    = ctrl;
        t_taps[num_tests]    = taps;
        t_coef_sh[num_tests] = coef_sh;
        t_amp_sh[num_tests]  = amp_sh;
        t_impulse[num_tests] = impulse;
        t_frames[num_tests]  = frames;
        t_gain[num_tests][0] = g0;
        t_gain[num_tests][1] = g1;
        t_gain[num_tests][2] = g2;
        t_gain[num_tests][3] = g3;
        num_tests++;
    endtask

    //////////////////// reference model
    function automatic longint sat24(input longint v);
        longint hi;
        hi = (longint'(1) << (SW - 1)) - 1;
        if (v > hi) return hi;
        if (v < -hi - 1) return -hi - 1;
        return v;
    endfunction

    // four filters, then weighted sum
    function automatic sample_t proc_chan(input int ch, input bit eq_byp);
        longint acc;
        longint mix;
        longint y;
        longint g;
        mix = 0;
        for (int f = 0; f < `AUD_NUM_FILTERS; f++) begin
            acc = 0;
            for (int t = 0; t < mtaps; t++) begin
                acc += longint'(mdl[ch][t]) * longint'(mcoef[f][t]);
            end
            y = sat24(acc >>> `AUD_COEF_FRAC);  // q1.15 back to sample scale
            g = eq_byp ? (longint'(1) << `AUD_GAIN_FRAC) : longint'(mgain[f]);
            mix += y * g;
        end
        return sample_t'(sat24(mix >>> `AUD_GAIN_FRAC));
    endfunction

    task automatic push_sample(input int ch, input sample_t s);
        for (int t = `AUD_MAX_TAPS - 1; t > 0; t--) begin
            mdl[ch][t] = mdl[ch][t-1];
        end
        mdl[ch][0] = s;
    endtask

    //////////////////// drivers
    task automatic send_frame(input sample_t l, input sample_t r);
        sample_t s;
        for (int h = 0; h < 2; h++) begin
            s = h ? r : l;
            for (int b = 0; b < SLOT; b++) begin
                @(posedge clk);
                i2s_bclk  <= 1'b0;                                    // lrclk and data move on the fall
                i2s_lrclk <= 1'(h);
                i2s_d     <= (b >= 1 && b <= SW) ? s[SW - b] : 1'b0;  // one-bit delay, msb first
                repeat (BCLK_HALF) @(posedge clk);
                i2s_bclk  <= 1'b1;
                repeat (BCLK_HALF - 1) @(posedge clk);
            end
        end
    endtask

    task automatic write_coefs(input int i);
        logic [31:0] raw;
        coef_t       c;
        for (int f = 0; f < `AUD_NUM_FILTERS; f++) begin
            for (int k = 0; k < t_taps[i]; k++) begin
                raw = $urandom;
                c   = coef_t'(raw[15:0]) >>> t_coef_sh[i];
                mcoef[f][k] = c;
                @(posedge clk);
                audio_control    <= {4'(f), 4'b0000};  // coef_sel picks the filter
                coef_wr_msb_data <= c[15:8];
                coef_wr_lsb_data <= c[7:0];
                coef_wr_en       <= 1'b1;
                @(posedge clk);
                coef_wr_en <= 1'b0;
                @(negedge clk);
                check_val("coef pointer zero", audio_status, ((k + 1) == t_taps[i]) ? 1 : 0);
            end
        end
    endtask

    task automatic write_gains(input int i);
        for (int g = 0; g < `AUD_NUM_FILTERS; g++) begin
            mgain[g] = t_gain[i][g];
            @(posedge clk);
            equalizer_select <= 8'(g + 4 * i);  // upper bits ignored
            eq_wr_msb_data   <= t_gain[i][g][15:8];
            eq_wr_lsb_data   <= t_gain[i][g][7:0];
            eq_wr_en         <= 1'b1;
            @(posedge clk);
            eq_wr_en <= 1'b0;
        end
    endtask

    task automatic run_test(input int i);
        int              err0;
        logic [31:0]     raw;
        sample_t         l;
        sample_t         r;
        logic [2*SW-1:0] got;
        logic [2*SW-1:0] exp;
        err0 = errors;
        @(posedge clk);
        taps_per_filter <= 8'(t_taps[i]);
        mtaps = t_taps[i];
        write_coefs(i);
        write_gains(i);
        @(posedge clk);
        audio_control <= t_ctrl[i];
        @(posedge clk);
        for (int k = 0; k < t_frames[i]; k++) begin
            if (t_impulse[i] && k == 0) begin
                l = sample_t'(24'h400000);  // half scale
                r = sample_t'(24'he00000);  // minus quarter scale
            end else begin
                raw = $urandom;
                l   = sample_t'(raw[SW-1:0]) >>> t_amp_sh[i];
                raw = $urandom;
                r   = sample_t'(raw[SW-1:0]) >>> t_amp_sh[i];
            end
            if (t_ctrl[i][0])
                exp_q.push_back({l, r});            // bypass passes the frame through
            else
                exp_q.push_back({held_l, held_r});  // one frame behind
            if (t_ctrl[i][2]) begin
                push_sample(0, l);
                push_sample(1, r);
                held_l = proc_chan(0, t_ctrl[i][1]);
                held_r = proc_chan(1, t_ctrl[i][1]);
            end
            send_frame(l, r);
        end
        while (got_q.size() < t_frames[i])
            @(posedge clk);
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            got = got_q.pop_front();
            check_val("dac left", got[2*SW-1:SW], exp[2*SW-1:SW]);
            check_val("dac right", got[SW-1:0], exp[SW-1:0]);
        end
        repeat (2 * PROC_CYC) @(posedge clk);  // let the last right sample drain
        check_val("extra dac frames", got_q.size(), 0);
        if (errors == err0) begin
            n_pass++;
            $display("test %0d %s: ok", i, t_name[i]);
        end else begin
            n_fail++;
            $display("test %0d %s: %0d errors", i, t_name[i], errors - err0);
        end
    endtask

    //////////////////// dac monitors
    logic [2:0] pin_hist [4];  // {bclk, lrclk, data}, 0 newest
    int         post_rst = 0;
    int         byp_run = 0;

    always @(negedge clk) begin
        check_val("dac_rst", dac_rst, !rst_n);
        for (int h = 3; h > 0; h--) begin
            pin_hist[h] = pin_hist[h-1];
        end
        pin_hist[0] = {i2s_bclk, i2s_lrclk, i2s_d};
        post_rst = rst_n ? post_rst + 1 : 0;
        byp_run  = (rst_n && audio_control[0]) ? byp_run + 1 : 0;
        if (post_rst >= 4) begin                        // three cycles of pipe filled
            check_val("dac_bclk delay", dac_bclk, pin_hist[3][2]);
            check_val("dac_lrclk delay", dac_lrclk, pin_hist[3][1]);
            if (byp_run >= 2)
                check_val("bypass dac_data", dac_data, pin_hist[3][0]);
        end
    end

    logic          mon_lr = 1'b0;
    logic          mon_bclk = 1'b0;
    int            mon_cnt = 0;     // 0 is the delay bit
    logic [SW-1:0] mon_sr;
    logic [SW-1:0] mon_left;

    always @(negedge clk) begin
        if (!rst_n) begin
            mon_cnt = 0;
        end else if (dac_lrclk != mon_lr) begin
            mon_cnt = 0;                                // new slot
        end else if (dac_bclk && !mon_bclk && mon_cnt <= SW) begin
            if (mon_cnt >= 1)
                mon_sr = {mon_sr[SW-2:0], dac_data};
            if (mon_cnt == SW) begin
                if (!dac_lrclk)
                    mon_left = mon_sr;
                else
                    got_q.push_back({mon_left, mon_sr});  // frame done on right slot
            end
            mon_cnt++;
        end
        mon_lr   = dac_lrclk;
        mon_bclk = dac_bclk;
    end

    //////////////////// main sequence
    initial begin
        int total_frames;
        void'($urandom(77444));
        rst_n            = 1'b0;
        i2s_bclk         = 1'b1;  // idle high, first frame starts on a fall
        i2s_lrclk        = 1'b1;
        i2s_d            = 1'b0;
        coef_wr_en       = 1'b0;
        eq_wr_en         = 1'b0;
        audio_control    = 8'h00;
        equalizer_select = 8'h00;
        taps_per_filter  = 8'h00;
        coef_wr_lsb_data = 8'h00;
        coef_wr_msb_data = 8'h00;
        eq_wr_lsb_data   = 8'h00;
        eq_wr_msb_data   = 8'h00;
        for (int c = 0; c < 2; c++) begin
            for (int t = 0; t < `AUD_MAX_TAPS; t++) begin
                mdl[c][t] = '0;
            end
        end

        // name, ctrl, taps, coef shift, amp shift, impulse, frames, gains 0..3
        add_test("audio_en clear from reset", 8'h00, 5, 1, 1, 0, 3,
                 16'sh4000, 16'sh4000, 16'sh4000, 16'sh4000);
        add_test("bypass lines", 8'h01, 4, 1, 0, 0, 3,
                 16'sh4000, 16'sh4000, 16'sh4000, 16'sh4000);
        add_test("eq bypass impulse", 8'h06, 16, 3, 2, 1, 6,
                 16'sh2000, 16'sh1000, -16'sh4000, 16'sh0800);  // gains ignored
        add_test("weighted gains", 8'h04, 7, 2, 0, 0, 6,
                 16'sh4000, -16'sh2000, 16'sh7fff, 16'sh1000);
        add_test("audio_en clear holds", 8'h00, 7, 2, 0, 0, 3,
                 16'sh4000, -16'sh2000, 16'sh7fff, 16'sh1000);

        total_frames = 0;
        for (int i = 0; i < num_tests; i++) begin
            total_frames += t_frames[i];
        end
        limit = total_frames * FRAME_CYC + (num_tests + 1) * 1000;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        check_val("reset dac_bclk", dac_bclk, 0);
        check_val("reset dac_lrclk", dac_lrclk, 0);
        check_val("reset dac_data", dac_data, 0);
        check_val("reset dac_rst", dac_rst, 1);
        check_val("reset status", audio_status, 1);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("dac_rst released", dac_rst, 0);
        check_val("status after reset", audio_status, 1);
        if (errors == 0) begin
            n_pass++;
            $display("test reset: ok");
        end else begin
            n_fail++;
            $display("test reset: %0d errors", errors);
        end

        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 n_pass + n_fail, n_pass, n_fail, n_checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
design/audio_pkg.sv
design/audio_regs_pkg.sv
design/audio_proc_top.sv
design/i2s_rx.sv
design/audio_ctrl.sv
design/fir_bank.sv
design/eq_mixer.sv
design/i2s_tx.sv
verif/audio_proc_tb.sv

/* Bender.yml */
package:
  name: audio_proc

export_include_dirs:
  - design

sources:
  - files:
      - design/audio_pkg.sv
      - design/audio_regs_pkg.sv
      - design/audio_proc_top.sv
      - design/i2s_rx.sv
      - design/audio_ctrl.sv
      - design/fir_bank.sv
      - design/eq_mixer.sv
      - design/i2s_tx.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/audio_proc_tb.sv
